//--- include/spi_params.svh
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// Word size of one SPI transfer, shifted LSB first
`define SPI_DATA_WIDTH  8

// clk cycles per SCLK half period
// SCLK frequency is clk / (2 * SPI_HALF_PERIOD)
`define SPI_HALF_PERIOD 4

// Edge counter width, must hold 2 * SPI_DATA_WIDTH SCLK edges
`define SPI_CNT_WIDTH   5

`endif

//--- rtl/spi_cfg_pkg.sv
package spi_cfg_pkg;

    // SPI mode as CPOL/CPHA pair, mode number is {cpol, cpha}
    typedef struct packed {
        logic cpol;                                             // SCLK idle level
        logic cpha;                                             // 0 sample on leading edge, 1 on trailing
    } spi_mode_t;

    // Mode 0 is what the master comes out of reset with
    localparam spi_mode_t SPI_MODE_RESET = '{cpol: 1'b0, cpha: 1'b0};

    // Role of an SCLK edge
    // Leading edge leaves the CPOL level, trailing edge returns to it
    function automatic logic is_sample_edge(spi_mode_t mode, logic leading);
        return leading ^ mode.cpha;                             // CPHA 0 samples leading, 1 trailing
    endfunction

endpackage

//--- rtl/spi_xfer_pkg.sv
`include "spi_params.svh"

package spi_xfer_pkg;

    // Transfer request from the host side
    typedef struct packed {
        logic                         start;                    // One-cycle start pulse
        spi_cfg_pkg::spi_mode_t       mode;                     // Mode for this transfer
        logic [`SPI_DATA_WIDTH-1:0]   tx_data;                  // Word sent on MOSI
    } spi_req_t;

    // Status and result back to the host side
    typedef struct packed {
        logic                         busy;                     // Transfer in progress
        logic                         done;                     // One-cycle completion pulse
        logic [`SPI_DATA_WIDTH-1:0]   rx_data;                  // Word received on MISO, held
    } spi_rsp_t;

    // Master-driven SPI pins
    typedef struct packed {
        logic                         sclk;
        logic                         mosi;
        logic                         cs_n;                     // Single slave select, active low
    } spi_pins_t;

    // One-cycle strobes, one per SCLK edge
    typedef struct packed {
        logic                         sample;                   // Capture MISO
        logic                         shift;                    // Advance MOSI
    } spi_edges_t;

endpackage

//--- rtl/spi_sclk_gen.sv
`include "spi_params.svh"

module spi_sclk_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,                       // High while SCLK should toggle
    input  spi_cfg_pkg::spi_mode_t   mode,                      // Latched transfer mode
    output logic                     sclk,
    output spi_xfer_pkg::spi_edges_t edges                      // Registered edge strobes
);

    import spi_cfg_pkg::*;

    localparam int                HALF_W    = $clog2(`SPI_HALF_PERIOD);
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`SPI_HALF_PERIOD - 1);

    logic [HALF_W-1:0] half_cnt;                                // clk cycles into current half period
    logic              phase;                                   // 1 while SCLK is away from CPOL
    logic              toggle;                                  // Last cycle of a half period
    logic              sample_now;                              // Role of the coming edge

    assign toggle     = run && (half_cnt == HALF_LAST);
    assign sample_now = is_sample_edge(mode, !phase);           // phase 0 means a leading edge is next

    // SCLK is CPOL with the phase laid over it, so it picks up a new CPOL
    // in the same cycle as the mode register
    assign sclk = mode.cpol ^ phase;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_cnt <= '0;
            phase    <= 1'b0;
        end else if (!run) begin
            half_cnt <= '0;                                     // Restart timing for next transfer
            phase    <= 1'b0;                                   // Park SCLK at CPOL
        end else if (toggle) begin
            half_cnt <= '0;
            phase    <= ~phase;                                 // SCLK edge
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // Strobes line up with the SCLK edge they describe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edges <= '0;
        end else begin
            edges.sample <= toggle &&  sample_now;
            edges.shift  <= toggle && !sample_now;
        end
    end

endmodule

//--- rtl/spi_master_ctrl.sv
`include "spi_params.svh"

module spi_master_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,                     // Start pulse from host
    input  spi_cfg_pkg::spi_mode_t   mode_in,                   // Requested mode
    input  spi_xfer_pkg::spi_edges_t edges,                     // Edge strobes from SCLK generator
    output spi_cfg_pkg::spi_mode_t   mode,                      // Mode held for the transfer
    output logic                     run,                       // Enables SCLK
    output logic                     load,                      // Parallel load of tx word
    output logic                     done,
    output logic                     busy,
    output logic                     cs_n
);

    import spi_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,                                                // cs_n high, waiting for start
        ST_XFER,                                                // cs_n low, SCLK running
        ST_FINISH                                               // done cycle
    } state_t;

    // Index of the final SCLK edge, counted from zero
    localparam logic [`SPI_CNT_WIDTH-1:0] LAST_EDGE =
        `SPI_CNT_WIDTH'(2 * `SPI_DATA_WIDTH - 1);

    state_t                    state;
    logic [`SPI_CNT_WIDTH-1:0] edge_cnt;                        // SCLK edges seen this transfer
    logic                      accept;                          // Start taken this cycle
    logic                      any_edge;

    assign accept   = start && (state == ST_IDLE);              // Start while busy is dropped
    assign any_edge = edges.sample || edges.shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            edge_cnt <= '0;
            mode     <= SPI_MODE_RESET;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state    <= ST_XFER;
                        edge_cnt <= '0;
                        mode     <= mode_in;                    // Held until next accept
                    end
                end
                ST_XFER: begin
                    if (any_edge) begin
                        if (edge_cnt == LAST_EDGE) begin
                            state <= ST_FINISH;                 // 2 x width edges done
                        end else begin
                            edge_cnt <= edge_cnt + 1'b1;
                        end
                    end
                end
                ST_FINISH: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Outputs decoded straight from state
    assign load = accept;
    assign run  = (state == ST_XFER);
    assign cs_n = (state != ST_XFER);                           // Deasserts with done
    assign done = (state == ST_FINISH);
    assign busy = (state != ST_IDLE);                           // Covers the done cycle too

endmodule

//--- rtl/spi_datapath.sv
`include "spi_params.svh"

module spi_datapath (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load,                    // Take tx_data in parallel
    input  logic                       done,                    // Transfer complete
    input  logic [`SPI_DATA_WIDTH-1:0] tx_data,
    input  spi_xfer_pkg::spi_edges_t   edges,
    input  logic                       miso,
    output logic                       mosi,
    output logic [`SPI_DATA_WIDTH-1:0] rx_data
);

    logic [`SPI_DATA_WIDTH-1:0] mosi_sr;                        // Outgoing word, bit 0 on the pin
    logic [`SPI_DATA_WIDTH-1:0] miso_sr;                        // Incoming word, fills from MSB
    logic [`SPI_DATA_WIDTH-1:0] rx_q;                           // Last completed word
    logic                       sampled;                        // A sample edge has passed since load

    // A shift edge before the first sample would drop bit 0 before the slave
    // reads it. That only happens with CPHA 1, where the first edge shifts.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sampled <= 1'b0;
        end else if (load) begin
            sampled <= 1'b0;
        end else if (edges.sample) begin
            sampled <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mosi_sr <= '0;                                      // MOSI low out of reset
        end else if (load) begin
            mosi_sr <= tx_data;                                 // Bit 0 goes out first
        end else if (edges.shift && sampled) begin
            mosi_sr <= mosi_sr >> 1;                            // Next bit onto MOSI
        end
    end

    always_ff @(posedge clk) begin
        if (edges.sample) begin
            miso_sr <= {miso, miso_sr[`SPI_DATA_WIDTH-1:1]};    // LSB first, ends up in bit 0
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_q <= '0;
        end else if (done) begin
            rx_q <= miso_sr;                                    // Hold until next done
        end
    end

    assign mosi = mosi_sr[0];

    // Completed word is already in miso_sr during done, so pass it through then
    assign rx_data = done ? miso_sr : rx_q;

endmodule

//--- rtl/spi_master_top.sv
module spi_master_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  spi_xfer_pkg::spi_req_t   req,                       // Start, mode and tx word
    input  logic                     miso,
    output spi_xfer_pkg::spi_rsp_t   rsp,                       // Busy, done and rx word
    output spi_xfer_pkg::spi_pins_t  pins                       // SCLK, MOSI, CS_N
);

    import spi_cfg_pkg::*;
    import spi_xfer_pkg::*;

    spi_mode_t                mode;                             // Mode latched by controller
    spi_edges_t               edges;                            // Sample and shift strobes
    logic                     run;
    logic                     load;

    spi_master_ctrl u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (req.start),
        .mode_in (req.mode),
        .edges   (edges),
        .mode    (mode),
        .run     (run),
        .load    (load),
        .done    (rsp.done),
        .busy    (rsp.busy),
        .cs_n    (pins.cs_n)
    );

    spi_sclk_gen u_sclk_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .mode  (mode),
        .sclk  (pins.sclk),
        .edges (edges)
    );

    spi_datapath u_datapath (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .done    (rsp.done),                                    // Also captures rx word
        .tx_data (req.tx_data),
        .edges   (edges),
        .miso    (miso),
        .mosi    (pins.mosi),
        .rx_data (rsp.rx_data)
    );

endmodule

//--- verification/spi_master_tb.sv
`include "spi_params.svh"

module spi_master_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import spi_cfg_pkg::*;
    import spi_xfer_pkg::*;

    localparam int          W          = `SPI_DATA_WIDTH;
    localparam int          CLK_HALF   = 4;                             // 8 ns clk period
    localparam int          TIMEOUT    = 200;                           // Cycles per wait loop
    localparam int          XFER_LAT   = 2 * `SPI_DATA_WIDTH * `SPI_HALF_PERIOD + 2;
    localparam int          MAX_VEC    = 48;
    localparam int          RESTART_AT = 20;                            // Cycle of the ignored start
    localparam int          RESET_AT   = 30;                            // Cycle of mid-transfer reset
    localparam logic [31:0] LFSR_SEED  = 32'h3dca9811;

    logic         clk;
    logic         rst_n;
    spi_req_t     req;
    logic         miso;
    spi_rsp_t     rsp;
    spi_pins_t    pins;

    logic [7:0]   vec_mem [0:6*MAX_VEC-1];                              // Six hex fields per transfer
    logic [31:0]  lfsr_q;
    logic         exp_cpol;                                             // SCLK level while deselected
    logic [W-1:0] held_rx;                                              // Word rx_data must hold
    spi_mode_t    slv_mode;                                             // Mode seen by the slave model
    logic [W-1:0] slv_word;                                             // Slave reply for this line
    logic [W-1:0] slv_rx;                                               // Word the slave captured

    spi_master_top DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .miso  (miso),
        .rsp   (rsp),
        .pins  (pins)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Galois LFSR, taps 32 22 2 1, right shifting
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end else begin
            return state >> 1;
        end
    endfunction

    task automatic stop_on_error();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    // Advance to the next falling edge, SCLK must rest at CPOL when deselected
    task automatic step_cycle();
        @(negedge clk);
        if (pins.cs_n) begin
            check_val("pins.sclk", 32'(pins.sclk), 32'(exp_cpol));
        end
    endtask

    task automatic apply_reset();
        rst_n    = 1'b0;
        exp_cpol = 1'b0;                                                // Master comes back in mode 0
        repeat (2) begin
            step_cycle();
            check_val("rsp.busy", 32'(rsp.busy), 32'd0);
            check_val("rsp.done", 32'(rsp.done), 32'd0);
            check_val("pins.cs_n", 32'(pins.cs_n), 32'd1);
            check_val("pins.sclk", 32'(pins.sclk), 32'd0);
            check_val("pins.mosi", 32'(pins.mosi), 32'd0);
            check_val("rsp.rx_data", 32'(rsp.rx_data), 32'd0);
        end
        rst_n   = 1'b1;
        held_rx = '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            step_cycle();
            check_val("rsp.busy", 32'(rsp.busy), 32'd0);
            check_val("rsp.done", 32'(rsp.done), 32'd0);
            check_val("pins.cs_n", 32'(pins.cs_n), 32'd1);
            check_val("rsp.rx_data", 32'(rsp.rx_data), 32'(held_rx));
        end
    endtask

    task automatic run_transfer(input spi_mode_t mode, input logic [W-1:0] mw,
                                input logic [W-1:0] sw, input logic restart,
                                input logic mid_reset);
        int   k;
        logic seen_done;
        logic aborted;
        k         = 0;
        seen_done = 1'b0;
        aborted   = 1'b0;
        slv_mode  = mode;
        slv_word  = sw;
        step_cycle();
        req.start   = 1'b1;                                             // Start cycle follows
        req.mode    = mode;
        req.tx_data = mw;
        while (!seen_done && !aborted) begin
            step_cycle();
            k++;
            if (k > TIMEOUT) begin
                $display("Timeout, no done within %0d cycles of start", TIMEOUT);
                stop_on_error();
            end
            if (k == 1) begin
                req.start = 1'b0;
                exp_cpol  = mode.cpol;                                  // New idle level once accepted
            end
            if (restart && k == RESTART_AT) begin
                req.start   = 1'b1;                                     // Must be ignored while busy
                req.mode    = spi_mode_t'(~mode);
                req.tx_data = ~mw;
            end
            if (restart && k == RESTART_AT + 1) begin
                req.start   = 1'b0;
                req.mode    = mode;
                req.tx_data = mw;
            end
            if (mid_reset && k == RESET_AT) begin
                apply_reset();
                aborted = 1'b1;
            end else if (rsp.done) begin
                seen_done = 1'b1;
                check_val("done latency", 32'(k), 32'(XFER_LAT));
                check_val("rsp.busy", 32'(rsp.busy), 32'd1);
                check_val("pins.cs_n", 32'(pins.cs_n), 32'd1);      // Rises with done
                check_val("rsp.rx_data", 32'(rsp.rx_data), 32'(sw));
                check_val("slave mosi word", 32'(slv_rx), 32'(mw));
                held_rx = sw;
            end else begin
                check_val("rsp.busy", 32'(rsp.busy), 32'd1);
                check_val("pins.cs_n", 32'(pins.cs_n), 32'd0);
                check_val("rsp.rx_data", 32'(rsp.rx_data), 32'(held_rx));
            end
        end
        if (!aborted) begin
            step_cycle();
            check_val("rsp.done", 32'(rsp.done), 32'd0);                // One-cycle pulse
            check_val("rsp.busy", 32'(rsp.busy), 32'd0);
            check_val("rsp.rx_data", 32'(rsp.rx_data), 32'(held_rx));
        end
    endtask

    // Slave model, LSB first both ways, reacts to SCLK edges seen at falling clk
    initial begin
        logic         prev_cs_n;
        logic         prev_sclk;
        logic         sampled;
        logic         leading;
        logic [W-1:0] tx_sr;
        prev_cs_n = 1'b1;
        prev_sclk = 1'b0;
        sampled   = 1'b0;
        tx_sr     = '0;
        slv_rx    = '0;
        miso      = 1'b0;
        forever begin
            @(negedge clk);
            if (pins.cs_n) begin
                sampled = 1'b0;                                         // Deselected, nothing to do
            end else if (prev_cs_n) begin
                tx_sr   = slv_word;                                     // Bit 0 ready before first edge
                slv_rx  = '0;
                sampled = 1'b0;
            end else if (pins.sclk != prev_sclk) begin
                leading = (pins.sclk != slv_mode.cpol);
                if (leading ^ slv_mode.cpha) begin
                    slv_rx  = {pins.mosi, slv_rx[W-1:1]};               // Sample edge
                    sampled = 1'b1;
                end else if (sampled) begin
                    tx_sr = tx_sr >> 1;                                 // Shift edge
                end
            end
            miso      = tx_sr[0];
            prev_cs_n = pins.cs_n;
            prev_sclk = pins.sclk;
        end
    end

    initial begin
        int         idx;
        int         base;
        logic [2:0] gap;
        spi_mode_t  mode;
        rst_n    = 1'b0;
        req      = '0;
        slv_mode = '0;
        slv_word = '0;
        exp_cpol = 1'b0;
        held_rx  = '0;
        lfsr_q   = LFSR_SEED;
        idx      = 0;
        $readmemh("verification/spi_input_vectors.txt", vec_mem);
        apply_reset();
        while (idx < MAX_VEC && vec_mem[6*idx] != 8'hff) begin
            base = 6 * idx;
            gap  = '0;
            repeat (3) begin
                gap    = {gap[1:0], lfsr_q[0]};                         // One LFSR step per bit
                lfsr_q = lfsr_step(lfsr_q);
            end
            idle_cycles(int'(gap));
            mode.cpol = vec_mem[base][0];
            mode.cpha = vec_mem[base+1][0];
            $display("Transfer %0d mode %0d tx 0x%0h rx 0x%0h", idx, mode,
                     vec_mem[base+2], vec_mem[base+3]);
            run_transfer(mode, vec_mem[base+2][W-1:0], vec_mem[base+3][W-1:0],
                         vec_mem[base+4][0], vec_mem[base+5][0]);
            idx++;
        end
        if (idx == 0) begin
            $display("No transfers were read from the vector file");
            stop_on_error();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

//--- verification/spi_input_vectors.txt
// SPI transfers, one per line, hex fields
// cpol cpha master_word slave_word restart_mid_xfer reset_mid_xfer
// master_word leaves on MOSI, slave_word comes back on MISO
// A line of ff ends the list
0 0 a5 3c 0 0
0 1 5a c3 0 0
1 0 ff 00 0 0
1 1 00 ff 0 0
0 0 01 80 0 0
0 1 80 01 1 0
1 0 3c a5 0 0
1 1 c3 5a 1 0
0 0 96 69 0 1
0 0 69 96 0 0
1 1 e7 18 0 0
1 0 18 e7 1 0
0 1 f0 0f 0 0
1 1 0f f0 0 1
1 1 2d d2 0 0
0 0 d2 2d 1 0
0 1 b4 4b 0 0
1 0 4b b4 0 0
1 1 77 88 0 0
0 0 88 77 0 0
0 1 13 ec 0 1
1 0 ec 13 0 0
0 0 c6 39 1 0
1 1 39 c6 0 0
1 0 aa 55 0 0
0 1 55 aa 0 0
0 0 7e 81 0 0
1 1 81 7e 1 0
0 1 02 40 0 0
1 0 40 02 0 0
1 0 c9 36 0 1
0 1 36 c9 0 0
ff ff ff ff ff ff

//--- all.f
+incdir+include
rtl/spi_cfg_pkg.sv
rtl/spi_xfer_pkg.sv
rtl/spi_sclk_gen.sv
rtl/spi_master_ctrl.sv
rtl/spi_datapath.sv
rtl/spi_master_top.sv
verification/spi_master_tb.sv

//--- Makefile
# Verilator simulation of the SPI master testbench
SIM_DIR := obj_dir
LOG     := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f all.f \
		--top-module spi_master_tb --Mdir $(SIM_DIR) -o spi_master_tb_sim
	./$(SIM_DIR)/spi_master_tb_sim | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(SIM_DIR) $(LOG)
